//--- include/memStage_config.svh
`ifndef MEMSTAGE_CONFIG_SVH
`define MEMSTAGE_CONFIG_SVH

// Set to 1'b0 for the build without the data cache
`define CACHE_ENABLE 1'b1

// First byte address of the data window
`define DATA_BASE 32'd1024

`define SRAM_ADDR_W 17
`define SRAM_WAIT_CYCLES 3

// Word address bit 0 picks the word within a line
`define CACHE_SETS 64
`define CACHE_INDEX_W $clog2(`CACHE_SETS)
`define CACHE_TAG_W (`SRAM_ADDR_W - `CACHE_INDEX_W - 1)

`endif

//--- rtl/pipeTypesPkg.sv
`default_nettype none
`include "memStage_config.svh"

package pipeTypesPkg;

    // Load or store coming from the execute stage
    typedef struct packed {
        logic        memRead;
        logic        memWrite;
        logic [31:0] addr;
        logic [31:0] storeData;
    } memRequest;

    // Carried unchanged towards writeback
    typedef struct packed {
        logic        wbEnable;
        logic [3:0]  dest;
        logic        memRead;
        logic [31:0] aluResult;
    } wbFields;

endpackage

`default_nettype wire

//--- rtl/memTypesPkg.sv
`default_nettype none
`include "memStage_config.svh"

package memTypesPkg;

    typedef struct packed {
        logic                    readEn;
        logic                    writeEn;
        logic [`SRAM_ADDR_W-1:0] addr;
        logic [31:0]             writeData;
    } sramRequest;

    // Lower half holds the even word
    typedef struct packed {
        logic [31:0] upper;
        logic [31:0] lower;
    } cacheLine;

    typedef struct packed {
        logic [`CACHE_TAG_W-1:0]   tag;
        logic [`CACHE_INDEX_W-1:0] index;
        logic                      wordSel;
    } cacheLookup;

    // All strobes active low
    typedef struct packed {
        logic weN;
        logic oeN;
        logic ceN;
        logic ubN;
        logic lbN;
    } sramPins;

    // Byte address inside the data window to SRAM word address
    function automatic logic [`SRAM_ADDR_W-1:0] toWordAddr(input logic [31:0] byteAddr);
        logic [31:0] offset;
        offset = byteAddr - `DATA_BASE;
        return offset[`SRAM_ADDR_W+1:2];
    endfunction

endpackage

`default_nettype wire

//--- rtl/sramController.sv
`timescale 1ns/1ps
`default_nettype none
`include "memStage_config.svh"

module sramController
    import memTypesPkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  sramRequest              sramReq,
    input  logic                    lineRead,
    output logic                    done,
    output cacheLine                lineData,
    output logic [`SRAM_ADDR_W-1:0] sramAddr,
    output sramPins                 sramCtrl,
    inout  wire  [31:0]             sramDq
);

    localparam int WaitW = $clog2(`SRAM_WAIT_CYCLES + 1);

    typedef enum logic [1:0] {
        sIdle,
        sEven,
        sOdd,
        sDone
    } sramState;

    sramState         state;
    logic [WaitW-1:0] waitCount;
    logic             active;
    logic             writing;
    logic             lastWait;

    assign active   = (state == sEven) || (state == sOdd);
    assign writing  = (state == sEven) && sramReq.writeEn;
    assign lastWait = (waitCount == WaitW'(`SRAM_WAIT_CYCLES - 1));
    assign done     = (state == sDone);

    // Line reads walk the even word, then the odd one
    always_comb begin
        sramAddr = sramReq.addr;
        if (lineRead) begin
            sramAddr[0] = (state == sOdd);
        end
    end

    always_comb begin
        sramCtrl.ceN = ~active;
        sramCtrl.oeN = ~(active && !sramReq.writeEn);
        sramCtrl.weN = ~writing;
        sramCtrl.ubN = ~active;
        sramCtrl.lbN = ~active;
    end

    assign sramDq = writing ? sramReq.writeData : 32'bz;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= sIdle;
            waitCount <= '0;
        end else begin
            case (state)
                sIdle: begin
                    if (sramReq.readEn || sramReq.writeEn) begin
                        state <= sEven;
                    end
                end
                sEven, sOdd: begin
                    waitCount <= waitCount + 1'b1;
                    if (lastWait) begin
                        waitCount <= '0;
                        if (state == sEven && lineRead && sramReq.readEn) begin
                            state <= sOdd;
                        end else begin
                            state <= sDone;
                        end
                    end
                end
                default: begin
                    state <= sIdle;
                end
            endcase
        end
    end

    // Sample read data on the last wait cycle
    always_ff @(posedge clk) begin
        if (active && lastWait && !sramReq.writeEn) begin
            if (state == sOdd) begin
                lineData.upper <= sramDq;
            end else begin
                lineData.lower <= sramDq;
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/dataCache.sv
`timescale 1ns/1ps
`default_nettype none
`include "memStage_config.svh"

module dataCache
    import memTypesPkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  cacheLookup  lookup,
    input  logic        fill,
    input  cacheLine    fillData,
    input  logic        invalidate,
    output logic        hit,
    output logic [31:0] readWord
);

    logic [`CACHE_TAG_W-1:0]       tagMem [2][`CACHE_SETS];
    cacheLine                      dataMem [2][`CACHE_SETS];
    logic [1:0][`CACHE_SETS-1:0]   valid;
    logic [`CACHE_SETS-1:0]        lru;
    logic [1:0]                    wayHit;
    logic                          hitWay;
    logic                          victim;
    cacheLine                      hitLine;

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            wayHit[w] = valid[w][lookup.index] &&
                        (tagMem[w][lookup.index] == lookup.tag);
        end
    end

    assign hit      = |wayHit;
    assign hitWay   = wayHit[1];
    assign hitLine  = dataMem[hitWay][lookup.index];
    assign readWord = lookup.wordSel ? hitLine.upper : hitLine.lower;

    // LRU bit names the way to replace next
    assign victim = lru[lookup.index];

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
            lru   <= '0;
        end else if (invalidate) begin
            for (int w = 0; w < 2; w++) begin
                if (wayHit[w]) begin
                    valid[w][lookup.index] <= 1'b0;
                end
            end
        end else if (fill) begin
            valid[victim][lookup.index] <= 1'b1;
            lru[lookup.index]           <= ~victim;
        end else if (hit) begin
            lru[lookup.index] <= ~hitWay;
        end
    end

    always_ff @(posedge clk) begin
        if (fill) begin
            tagMem[victim][lookup.index]  <= lookup.tag;
            dataMem[victim][lookup.index] <= fillData;
        end
    end

endmodule

`default_nettype wire

//--- rtl/cacheController.sv
`timescale 1ns/1ps
`default_nettype none
`include "memStage_config.svh"

module cacheController
    import pipeTypesPkg::*;
    import memTypesPkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  memRequest   req,
    input  logic        hit,
    input  logic [31:0] readWord,
    input  logic        sramDone,
    input  cacheLine    lineData,
    output cacheLookup  lookup,
    output logic        fill,
    output cacheLine    fillData,
    output logic        invalidate,
    output sramRequest  sramReq,
    output logic        lineRead,
    output logic        ready,
    output logic [31:0] memData
);

    typedef enum logic [1:0] {
        sLookup,
        sReadLine,
        sFill,
        sWrite
    } ctrlState;

    ctrlState                state;
    logic [`SRAM_ADDR_W-1:0] wordAddr;
    logic                    reqPresent;
    logic                    readHit;

    assign wordAddr = toWordAddr(req.addr);

    assign lookup = '{
        tag:     wordAddr[`SRAM_ADDR_W-1:`CACHE_INDEX_W+1],
        index:   wordAddr[`CACHE_INDEX_W:1],
        wordSel: wordAddr[0]
    };

    assign sramReq = '{
        readEn:    (state == sReadLine),
        writeEn:   (state == sWrite),
        addr:      wordAddr,
        writeData: req.storeData
    };

    assign lineRead   = (state == sReadLine);
    assign fill       = (state == sFill);
    assign fillData   = lineData;
    assign invalidate = (state == sWrite) && sramDone;

    assign reqPresent = req.memRead || req.memWrite;
    assign readHit    = (state == sLookup) && req.memRead && hit;
    assign ready      = !reqPresent || readHit || invalidate;
    assign memData    = readWord;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= sLookup;
        end else begin
            case (state)
                sLookup: begin
                    if (req.memRead && !hit) begin
                        state <= sReadLine;
                    end else if (req.memWrite) begin
                        state <= sWrite;
                    end
                end
                sReadLine: begin
                    if (sramDone) begin
                        state <= sFill;
                    end
                end
                // Filled line turns the held load into a hit
                sFill: begin
                    state <= sLookup;
                end
                default: begin
                    if (sramDone) begin
                        state <= sLookup;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- rtl/memStage.sv
`timescale 1ns/1ps
`default_nettype none
`include "memStage_config.svh"

module memStage
    import pipeTypesPkg::*;
    import memTypesPkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  memRequest               req,
    input  wbFields                 wb,
    output logic                    ready,
    output wbFields                 wbOut,
    output logic [31:0]             memData,
    output logic [`SRAM_ADDR_W-1:0] sramAddr,
    output sramPins                 sramCtrl,
    inout  wire  [31:0]             sramDq
);

    sramRequest sramReq;
    logic       lineRead;
    logic       sramDone;
    cacheLine   lineData;

    assign wbOut = wb;

    sramController i_sramController (
        .clk      (clk),
        .rst      (rst),
        .sramReq  (sramReq),
        .lineRead (lineRead),
        .done     (sramDone),
        .lineData (lineData),
        .sramAddr (sramAddr),
        .sramCtrl (sramCtrl),
        .sramDq   (sramDq)
    );

    generate
        if (`CACHE_ENABLE) begin : gCached
            cacheLookup  lookup;
            cacheLine    fillData;
            logic        fill;
            logic        invalidate;
            logic        hit;
            logic [31:0] readWord;

            dataCache i_dataCache (
                .clk        (clk),
                .rst        (rst),
                .lookup     (lookup),
                .fill       (fill),
                .fillData   (fillData),
                .invalidate (invalidate),
                .hit        (hit),
                .readWord   (readWord)
            );

            cacheController i_cacheController (
                .clk        (clk),
                .rst        (rst),
                .req        (req),
                .hit        (hit),
                .readWord   (readWord),
                .sramDone   (sramDone),
                .lineData   (lineData),
                .lookup     (lookup),
                .fill       (fill),
                .fillData   (fillData),
                .invalidate (invalidate),
                .sramReq    (sramReq),
                .lineRead   (lineRead),
                .ready      (ready),
                .memData    (memData)
            );
        end else begin : gUncached
            // Single-word accesses straight to the SRAM
            assign sramReq = '{
                readEn:    req.memRead,
                writeEn:   req.memWrite,
                addr:      toWordAddr(req.addr),
                writeData: req.storeData
            };
            assign lineRead = 1'b0;
            assign ready    = !(req.memRead || req.memWrite) || sramDone;
            assign memData  = lineData.lower;
        end
    endgenerate

endmodule

`default_nettype wire

//--- tb/sramModel.sv
`timescale 1ns/1ps
`default_nettype none
`include "memStage_config.svh"

module sramModel
    import memTypesPkg::*;
(
    input  logic                    clk,
    input  logic [`SRAM_ADDR_W-1:0] addr,
    input  sramPins                 ctrl,
    inout  wire  [31:0]             dq
);

    localparam int Depth = 1 << `SRAM_ADDR_W;

    logic [31:0] mem [Depth];
    logic        reading;
    logic        lanesOn;

    // Power-up contents depend on the whole address
    initial begin
        for (int i = 0; i < Depth; i++) begin
            mem[i] = {i[16:0] ^ 17'h1b5a3, ~i[14:0]};
        end
    end

    // Word accesses need both byte lanes
    assign lanesOn = !ctrl.ubN && !ctrl.lbN;
    assign reading = !ctrl.ceN && !ctrl.oeN && ctrl.weN && lanesOn;
    assign dq      = reading ? mem[addr] : 32'bz;

    // Write strobe sampled on the clock
    always @(posedge clk) begin
        if (!ctrl.ceN && !ctrl.weN && lanesOn) begin
            mem[addr] <= dq;
        end
    end

endmodule

`default_nettype wire

//--- tb/tbClock.sv
`timescale 1ns/1ps
`default_nettype none

module tbClock #(
    parameter int PeriodNs = 40
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PeriodNs / 2) clk = ~clk;
    end

endmodule

`default_nettype wire

//--- tb/memStageTb.sv
`timescale 1ns/1ps
`default_nettype none
`include "memStage_config.svh"

module memStageTb
    import pipeTypesPkg::*;
    import memTypesPkg::*;
();

    localparam int TimeoutCycles = 50;

    logic                    clk;
    logic                    rst;
    memRequest               req;
    wbFields                 wb;
    logic                    ready;
    wbFields                 wbOut;
    logic [31:0]             memData;
    logic [`SRAM_ADDR_W-1:0] sramAddr;
    sramPins                 sramCtrl;
    wire  [31:0]             sramDq;

    logic [31:0] lcgState;
    logic [31:0] refMem [int];
    int          mismatchCount;
    int          timeoutCount;

    tbClock #(.PeriodNs(40)) i_tbClock (.clk(clk));

    memStage i_memStage (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .wb       (wb),
        .ready    (ready),
        .wbOut    (wbOut),
        .memData  (memData),
        .sramAddr (sramAddr),
        .sramCtrl (sramCtrl),
        .sramDq   (sramDq)
    );

    sramModel i_sramModel (
        .clk  (clk),
        .addr (sramAddr),
        .ctrl (sramCtrl),
        .dq   (sramDq)
    );

    function automatic logic [31:0] nextRandom();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    // SRAM word before any store reached it
    function automatic logic [31:0] initialWord(input int wordIdx);
        logic [16:0] w;
        w = wordIdx[16:0];
        return {w ^ 17'h1b5a3, ~w[14:0]};
    endfunction

    function automatic logic [31:0] expectedWord(input int wordIdx);
        if (refMem.exists(wordIdx)) begin
            return refMem[wordIdx];
        end
        return initialWord(wordIdx);
    endfunction

    function automatic logic [31:0] byteAddr(input int wordIdx);
        return `DATA_BASE + 32'(wordIdx) * 4;
    endfunction

    function automatic wbFields makeWb(input logic isLoad, input logic [31:0] addr);
        logic [31:0] r;
        r = nextRandom();
        return '{wbEnable: r[0], dest: r[4:1], memRead: isLoad, aluResult: addr};
    endfunction

    task automatic checkWord(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Mismatch %s: got %h, expected %h", name, actual, expected);
            mismatchCount++;
        end
    endtask

    task automatic checkWb(input wbFields actual, input wbFields expected);
        if (actual !== expected) begin
            $display("Mismatch wbOut: got %h, expected %h", actual, expected);
            mismatchCount++;
        end
    endtask

    task automatic checkFlag(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("Mismatch %s: got %h, expected %h", name, actual, expected);
            mismatchCount++;
        end
    endtask

    task automatic startAccess(input memRequest r, input wbFields w);
        @(posedge clk);
        req <= r;
        wb  <= w;
    endtask

    // Address stays put so the idle lookup matches the last access
    task automatic endAccess();
        @(posedge clk);
        req.memRead  <= 1'b0;
        req.memWrite <= 1'b0;
    endtask

    task automatic waitReady(input wbFields expWb, output logic firstReady,
                             output logic ok);
        int cycles;
        cycles     = 0;
        ok         = 1'b0;
        firstReady = 1'b0;
        while (!ok && cycles < TimeoutCycles) begin
            @(negedge clk);
            checkWb(wbOut, expWb);
            if (cycles == 0) begin
                firstReady = ready;
            end
            ok = (ready === 1'b1);
            cycles++;
        end
        if (!ok) begin
            $display("Timeout: ready stayed low for %0d cycles", TimeoutCycles);
            timeoutCount++;
        end
    endtask

    // Every store waits for the SRAM write
    task automatic storeWord(input int wordIdx, input logic [31:0] data);
        memRequest r;
        wbFields   w;
        logic      firstReady;
        logic      ok;
        r = '{memRead: 1'b0, memWrite: 1'b1, addr: byteAddr(wordIdx), storeData: data};
        w = makeWb(1'b0, r.addr);
        startAccess(r, w);
        waitReady(w, firstReady, ok);
        checkFlag($sformatf("ready on store request, word %0d", wordIdx), firstReady, 1'b0);
        refMem[wordIdx] = data;
        endAccess();
    endtask

    // Only a hit is ready on the request cycle
    task automatic loadWord(input int wordIdx, input logic expectHit);
        memRequest r;
        wbFields   w;
        logic      firstReady;
        logic      ok;
        r = '{memRead: 1'b1, memWrite: 1'b0, addr: byteAddr(wordIdx),
              storeData: nextRandom()};
        w = makeWb(1'b1, r.addr);
        startAccess(r, w);
        waitReady(w, firstReady, ok);
        checkFlag($sformatf("ready on request, word %0d", wordIdx), firstReady, expectHit);
        if (ok) begin
            checkWord($sformatf("memData, word %0d", wordIdx), memData,
                      expectedWord(wordIdx));
        end
        endAccess();
    endtask

    task automatic idleAfterReset();
        @(negedge clk);
        checkFlag("ready", ready, 1'b1);
        checkFlag("sramCtrl.weN", sramCtrl.weN, 1'b1);
        checkFlag("sramCtrl.oeN", sramCtrl.oeN, 1'b1);
        checkFlag("sramCtrl.ceN", sramCtrl.ceN, 1'b1);
    endtask

    task automatic storeThenLoad();
        storeWord(20, nextRandom());
        loadWord(20, 1'b0);
    endtask

    task automatic repeatLoadHits();
        loadWord(20, 1'b1);
        loadWord(21, 1'b1);
    endtask

    task automatic storeInvalidatesLine();
        storeWord(20, nextRandom());
        loadWord(20, 1'b0);
        loadWord(20, 1'b1);
    endtask

    // Same index with tags 0, 1 and 2
    task automatic lruRefill();
        loadWord(10, 1'b0);
        loadWord(10 + 128, 1'b0);
        loadWord(10 + 256, 1'b0);
        loadWord(10, 1'b0);
        loadWord(10 + 256, 1'b1);
        loadWord(10 + 128, 1'b0);
    endtask

    initial begin
        lcgState      = 32'h7a6ea1a8;
        mismatchCount = 0;
        timeoutCount  = 0;
        rst           = 1'b1;
        req           = '0;
        wb            = '0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;

        idleAfterReset();
        storeThenLoad();
        repeatLoadHits();
        storeInvalidatesLine();
        lruRefill();

        $display("Result: %0d mismatches, %0d timeouts", mismatchCount, timeoutCount);
        if (mismatchCount == 0 && timeoutCount == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
+incdir+include
rtl/pipeTypesPkg.sv
rtl/memTypesPkg.sv
rtl/sramController.sv
rtl/dataCache.sv
rtl/cacheController.sv
rtl/memStage.sv
tb/sramModel.sv
tb/tbClock.sv
tb/memStageTb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal -j 0
TOP       ?= memStageTb
FILELIST  ?= compile.f
OBJDIR    ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "Simulation passed"

clean:
	rm -rf $(OBJDIR)
